/* Makefile */
SIM     ?= verilator
TOP     ?= tb_bus_subsystem
FLIST   ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing --assert -Wno-fatal
LOG     ?= sim.log
VECTORS ?= tb_input_vectors.txt

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) $(VECTORS)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
bus_pkg.sv
bus_arbiter.sv
arb_config_regs.sv
bus_target_mem.sv
bus_subsystem_top.sv
tb_bus_subsystem.sv

/* arb_config_regs.sv */
module arb_config_regs
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [data_w-1:0]     pwdata,
    input  logic [n_masters-1:0]  grant,
    input  logic                  ack,
    output logic [data_w-1:0]     prdata,
    output logic                  pready,
    output logic [n_masters-1:0]  enable_mask,
    output logic                  mode
);

    // one saturating counter per master
    logic [cnt_w-1:0] cnt [n_masters];

    // write strobe in the access cycle of an APB write
    logic apb_wr;

    // any write to a counter offset clears all counters
    logic cnt_clear;

    assign apb_wr = psel & penable & pwrite;
    assign cnt_clear = apb_wr &&
        (paddr == reg_cnt0 || paddr == reg_cnt1 || paddr == reg_cnt2);

    // the block never inserts wait states
    assign pready = 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable_mask <= mask_reset;
            mode <= mode_fixed;
        end else if (apb_wr && paddr == reg_ctrl) begin
            enable_mask <= pwdata[n_masters-1:0];
            mode <= pwdata[ctrl_mode_bit];
        end
    end

    // a transfer counts once for its master on the edge where ack is seen
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < n_masters; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < n_masters; i++) begin
                if (cnt_clear) begin
                    cnt[i] <= '0;
                end else if (ack && grant[i] && cnt[i] != '1) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    // read data follows paddr so it is valid throughout the access cycle
    always_comb begin
        prdata = '0;
        case (paddr)
            reg_ctrl: begin
                prdata[n_masters-1:0] = enable_mask;
                prdata[ctrl_mode_bit] = mode;
            end
            reg_cnt0: begin
                prdata[cnt_w-1:0] = cnt[0];
            end
            reg_cnt1: begin
                prdata[cnt_w-1:0] = cnt[1];
            end
            reg_cnt2: begin
                prdata[cnt_w-1:0] = cnt[2];
            end
            // unmapped offsets read as zero
            default: begin
                prdata = '0;
            end
        endcase
    end

    // an access phase only follows a setup phase of the same transfer
    a_apb_setup_first: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> (psel && $past(psel)));

endmodule

/* bus_arbiter.sv */
module bus_arbiter
    import bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [n_masters-1:0] req,
    input  logic [n_masters-1:0] enable_mask,
    input  logic                 mode,
    input  logic                 ack,
    output logic [n_masters-1:0] grant
);

    // current state, idle means grant is zero
    logic state;

    // index where the round-robin search starts when no grant is held
    logic [idx_w-1:0] rr_ptr;

    // requests that are allowed to compete
    logic [n_masters-1:0] cand;

    // one-hot winner of the current candidate set, zero if nobody requests
    logic [n_masters-1:0] next_grant;

    // index of the master holding the grant
    logic [idx_w-1:0] grant_idx;

    // first index examined by the search
    logic [idx_w-1:0] start_idx;

    // step to the next master and wrap after the last one
    function automatic logic [idx_w-1:0] next_idx(input logic [idx_w-1:0] i);
        logic [idx_w-1:0] n;
        if (i == idx_w'(n_masters - 1)) begin
            n = '0;
        end else begin
            n = i + 1'b1;
        end
        return n;
    endfunction

    assign cand = req & enable_mask;

    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < n_masters; i++) begin
            if (grant[i]) begin
                grant_idx = idx_w'(i);
            end
        end
    end

    // fixed priority always searches from master 0
    // in round-robin mode the search begins after the master that holds the grant
    // so that re-arbitration at the ack edge already skips it
    always_comb begin
        if (mode == mode_rr) begin
            start_idx = (grant != no_grant) ? next_idx(grant_idx) : rr_ptr;
        end else begin
            start_idx = '0;
        end
    end

    // walk all masters once starting at start_idx and take the first candidate
    always_comb begin : pick
        logic [idx_w-1:0] probe;
        logic             found;
        probe = start_idx;
        found = 1'b0;
        next_grant = no_grant;
        for (int k = 0; k < n_masters; k++) begin
            if (!found && cand[probe]) begin
                next_grant[probe] = 1'b1;
                found = 1'b1;
            end
            probe = next_idx(probe);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            grant <= no_grant;
            rr_ptr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // a grant is issued on the first edge that sees a masked request
                    grant <= next_grant;
                    state <= (cand != no_grant) ? st_busy : st_idle;
                end
                st_busy: begin
                    // the grant is held until the target acknowledges
                    if (ack) begin
                        grant <= next_grant;
                        state <= (cand != no_grant) ? st_busy : st_idle;
                        rr_ptr <= next_idx(grant_idx);
                    end
                end
                default: begin
                    state <= st_idle;
                    grant <= no_grant;
                end
            endcase
        end
    end

    // at most one master owns the bus
    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant));

    // an owner keeps the bus until its transfer has been acknowledged
    a_grant_stable: assert property (@(posedge clk) disable iff (reset)
        (grant != no_grant && !ack) |=> $stable(grant));

    // every newly loaded grant answers an enabled request of the previous cycle
    a_grant_had_request: assert property (@(posedge clk) disable iff (reset)
        (grant != no_grant && ($past(ack) || $past(grant) == no_grant))
        |-> (($past(req & enable_mask) & grant) != no_grant));

endmodule

/* bus_pkg.sv */
package bus_pkg;

    // number of masters sharing the bus
    localparam int n_masters = 3;

    // bits needed to hold the index of one master
    localparam int idx_w = $clog2(n_masters);

    // the target memory has 16 words addressed by a 4 bit word address
    localparam int addr_w = 4;
    localparam int mem_words = 1 << addr_w;

    // width of bus and APB data
    localparam int data_w = 32;

    // grant counters saturate at all ones
    localparam int cnt_w = 16;

    // APB byte offsets of the register block
    localparam int apb_addr_w = 8;
    localparam logic [apb_addr_w-1:0] reg_ctrl = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_cnt0 = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_cnt1 = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_cnt2 = 8'h0C;

    // the control register keeps the enable mask in its low bits and the mode in bit 8
    localparam int ctrl_mode_bit = 8;
    localparam logic [n_masters-1:0] mask_reset = '1;

    // values of the mode bit
    localparam logic mode_fixed = 1'b0;
    localparam logic mode_rr = 1'b1;

    // states of the arbiter
    localparam logic st_idle = 1'b0;
    localparam logic st_busy = 1'b1;

    // grant vector with no master selected
    localparam logic [n_masters-1:0] no_grant = '0;

endpackage

/* bus_subsystem_top.sv */
module bus_subsystem_top
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // APB port of the register block
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [data_w-1:0]     pwdata,
    output logic [data_w-1:0]     prdata,
    output logic                  pready,
    // master requests
    input  logic [n_masters-1:0]  req,
    input  logic [addr_w-1:0]     m0_addr,
    input  logic [addr_w-1:0]     m1_addr,
    input  logic [addr_w-1:0]     m2_addr,
    input  logic [data_w-1:0]     m0_wdata,
    input  logic [data_w-1:0]     m1_wdata,
    input  logic [data_w-1:0]     m2_wdata,
    input  logic [n_masters-1:0]  write,
    // bus response
    output logic [n_masters-1:0]  grant,
    output logic                  ack,
    output logic [data_w-1:0]     rdata
);

    // arbiter settings from the register block
    logic [n_masters-1:0] enable_mask;
    logic                 mode;

    bus_arbiter u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .enable_mask (enable_mask),
        .mode        (mode),
        .ack         (ack),
        .grant       (grant)
    );

    // the register block also watches grant and ack to count transfers
    arb_config_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .grant       (grant),
        .ack         (ack),
        .prdata      (prdata),
        .pready      (pready),
        .enable_mask (enable_mask),
        .mode        (mode)
    );

    bus_target_mem u_target (
        .clk      (clk),
        .reset    (reset),
        .grant    (grant),
        .m0_addr  (m0_addr),
        .m1_addr  (m1_addr),
        .m2_addr  (m2_addr),
        .m0_wdata (m0_wdata),
        .m1_wdata (m1_wdata),
        .m2_wdata (m2_wdata),
        .write    (write),
        .ack      (ack),
        .rdata    (rdata)
    );

endmodule

/* bus_target_mem.sv */
module bus_target_mem
    import bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [n_masters-1:0] grant,
    input  logic [addr_w-1:0]    m0_addr,
    input  logic [addr_w-1:0]    m1_addr,
    input  logic [addr_w-1:0]    m2_addr,
    input  logic [data_w-1:0]    m0_wdata,
    input  logic [data_w-1:0]    m1_wdata,
    input  logic [data_w-1:0]    m2_wdata,
    input  logic [n_masters-1:0] write,
    output logic                 ack,
    output logic [data_w-1:0]    rdata
);

    // storage of the target
    logic [data_w-1:0] mem [mem_words];

    // master requests gathered into arrays for the mux
    logic [addr_w-1:0] m_addr  [n_masters];
    logic [data_w-1:0] m_wdata [n_masters];

    // request of the granted master
    logic [addr_w-1:0] sel_addr;
    logic [data_w-1:0] sel_wdata;
    logic              sel_write;

    // a transfer is served when a grant is present and no ack is pending
    logic access;

    assign m_addr[0] = m0_addr;
    assign m_addr[1] = m1_addr;
    assign m_addr[2] = m2_addr;
    assign m_wdata[0] = m0_wdata;
    assign m_wdata[1] = m1_wdata;
    assign m_wdata[2] = m2_wdata;

    // grant is one-hot so OR-ing the gated fields picks exactly one master
    always_comb begin
        sel_addr = '0;
        sel_wdata = '0;
        for (int i = 0; i < n_masters; i++) begin
            if (grant[i]) begin
                sel_addr = sel_addr | m_addr[i];
                sel_wdata = sel_wdata | m_wdata[i];
            end
        end
    end

    assign sel_write = |(grant & write);

    // while ack is high the arbiter is loading the next grant
    // so the following access waits one cycle and ack becomes a pulse
    assign access = (grant != no_grant) && !ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // the memory starts out cleared
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (access && sel_write) begin
            mem[sel_addr] <= sel_wdata;
        end
    end

    // read data is returned together with the ack pulse
    // a write leaves the last read word in place
    always_ff @(posedge clk) begin
        if (access && !sel_write) begin
            rdata <= mem[sel_addr];
        end
    end

    // the acknowledge lasts exactly one cycle
    a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        ack |=> !ack);

endmodule

/* tb_bus_subsystem.sv */
module tb_bus_subsystem
    import bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // cycles allowed between two bus events before the run is abandoned
    localparam int ack_timeout = 20;

    // cycles over which a masked request must stay without a grant
    localparam int block_window = 4;

    logic                  clk;
    logic                  reset;
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [data_w-1:0]     pwdata;
    logic [data_w-1:0]     prdata;
    logic                  pready;
    logic [n_masters-1:0]  req;
    logic [addr_w-1:0]     m0_addr;
    logic [addr_w-1:0]     m1_addr;
    logic [addr_w-1:0]     m2_addr;
    logic [data_w-1:0]     m0_wdata;
    logic [data_w-1:0]     m1_wdata;
    logic [data_w-1:0]     m2_wdata;
    logic [n_masters-1:0]  write;
    logic [n_masters-1:0]  grant;
    logic                  ack;
    logic [data_w-1:0]     rdata;

    bus_subsystem_top u_dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR at time %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    // one APB transfer, setup cycle then access cycle until pready is seen
    task automatic apb_transfer(input logic [apb_addr_w-1:0] off, input logic wr,
                                input logic [data_w-1:0] wdata_in,
                                output logic [data_w-1:0] rdata_out);
        int waited;
        waited = 0;
        @(posedge clk);
        paddr <= off;
        pwrite <= wr;
        pwdata <= wdata_in;
        psel <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready) begin
            waited++;
            if (waited > ack_timeout) begin
                abort_run("the APB slave never raised pready");
            end
            @(posedge clk);
        end
        // prdata follows paddr, so the value seen at the access edge is the read word
        rdata_out = prdata;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    // all selected masters request together and each retires after its access
    task automatic bus_transfer(input logic [n_masters-1:0] req_mask,
                                input logic [n_masters-1:0] wr_mask,
                                input logic [addr_w-1:0] addr, input logic [data_w-1:0] base,
                                input logic [n_masters-1:0] g0, input logic [n_masters-1:0] g1,
                                input logic [n_masters-1:0] g2,
                                input logic [data_w-1:0] exp_rdata);
        logic [n_masters-1:0] seq [3];
        int                   n_exp;
        int                   n_acks;
        int                   waited;
        seq[0] = g0;
        seq[1] = g1;
        seq[2] = g2;
        n_exp = 0;
        for (int i = 0; i < 3; i++) begin
            if (seq[i] != no_grant) begin
                n_exp++;
            end
        end
        @(posedge clk);
        m0_addr <= addr;
        m1_addr <= addr;
        m2_addr <= addr;
        m0_wdata <= base;
        m1_wdata <= base + 32'd1;
        m2_wdata <= base + 32'd2;
        write <= wr_mask;
        req <= req_mask;
        n_acks = 0;
        waited = 0;
        while (n_acks < n_exp) begin
            @(posedge clk);
            waited++;
            if (waited > ack_timeout) begin
                abort_run("no ack arrived within 20 cycles");
            end
            // the target takes the request at this edge, so the owner retires it here
            // and the arbiter does not see it again at the ack edge
            if (grant != no_grant && !ack) begin
                req <= req & ~grant;
            end
            if (ack) begin
                check_value("grant", 32'(seq[n_acks]), 32'(grant));
                if ((grant & wr_mask) == no_grant) begin
                    check_value("rdata", exp_rdata, rdata);
                end
                // under continuous requests an ack comes every second cycle
                if (n_acks > 0) begin
                    check_value("ack spacing", 32'd2, 32'(waited));
                end
                n_acks++;
                waited = 0;
            end
        end
        // requests of disabled masters are still pending and must never win
        if (req != no_grant) begin
            for (int c = 0; c < block_window; c++) begin
                @(posedge clk);
                check_value("grant of a masked master", 32'd0, 32'(grant));
            end
        end
        req <= no_grant;
    endtask

    initial begin
        int                fd;
        int                n;
        int                ch;
        bit                done;
        logic [7:0]        cmd;
        logic [31:0]       f [8];
        logic [data_w-1:0] rd;
        reset = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        req = '0;
        write = '0;
        m0_addr = '0;
        m1_addr = '0;
        m2_addr = '0;
        m0_wdata = '0;
        m1_wdata = '0;
        m2_wdata = '0;
        done = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("grant", 32'd0, 32'(grant));
        check_value("ack", 32'd0, 32'(ack));
        fd = $fopen("tb_input_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb_input_vectors.txt");
        end
        while (!done) begin
            n = $fscanf(fd, " %c", cmd);
            if (n != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": begin
                        ch = $fgetc(fd);
                        while (ch != 10 && ch != -1) begin
                            ch = $fgetc(fd);
                        end
                    end
                    "A": begin
                        if ($fscanf(fd, " %h %h", f[0], f[1]) != 2) begin
                            abort_run("malformed APB write line in the vector file");
                        end
                        apb_transfer(f[0][apb_addr_w-1:0], 1'b1, f[1], rd);
                    end
                    "R": begin
                        if ($fscanf(fd, " %h %h", f[0], f[1]) != 2) begin
                            abort_run("malformed APB read line in the vector file");
                        end
                        apb_transfer(f[0][apb_addr_w-1:0], 1'b0, '0, rd);
                        check_value($sformatf("prdata at offset %h", f[0][7:0]), f[1], rd);
                    end
                    "T": begin
                        if ($fscanf(fd, " %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                                    f[4], f[5], f[6], f[7]) != 8) begin
                            abort_run("malformed bus transfer line in the vector file");
                        end
                        bus_transfer(f[0][n_masters-1:0], f[1][n_masters-1:0],
                                     f[2][addr_w-1:0], f[3], f[4][n_masters-1:0],
                                     f[5][n_masters-1:0], f[6][n_masters-1:0], f[7]);
                    end
                    default: begin
                        abort_run($sformatf("unknown command %c in the vector file", cmd));
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* tb_input_vectors.txt */
# A offset data | R offset expected | T req write addr wdata_base grant0 grant1 grant2 rdata
# all fields hex, master i writes wdata_base + i, a zero grant entry is unused
R 00 00000007
R 04 00000000
R 08 00000000
R 0C 00000000
T 7 7 3 11110000 1 2 4 00000000
T 3 0 3 00000000 1 2 0 11110002
T 4 4 5 22220000 4 0 0 00000000
T 1 0 5 00000000 1 0 0 22220002
A 00 00000006
T 5 5 7 33330000 4 0 0 00000000
A 00 00000007
T 1 0 7 00000000 1 0 0 33330002
A 00 00000107
R 00 00000107
T 7 0 3 00000000 2 4 1 11110002
T 4 0 5 00000000 4 0 0 22220002
T 7 7 9 44440000 1 2 4 00000000
T 6 0 9 00000000 2 4 0 44440002
R 04 00000006
R 08 00000005
R 0C 00000007
A 04 00000000
R 04 00000000
R 08 00000000
R 0C 00000000
